/* hw/cp0_regs.sv */
// cp0_regs: status, cause, epc and badvaddr with mtc0 access and exception/eret updates
`timescale 1ns/10ps
`default_nettype none
`include "mango_defines.svh"

module cp0_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`MANGO_HWINT_W-1:0]  hw_int,
    input  mango_pkg::exc_type_e       exc_type,
    input  logic [`MANGO_ADDR_W-1:0]   exc_baddr,
    input  logic [`MANGO_ADDR_W-1:0]   pc,
    input  logic                       cp0_we,
    input  logic [`MANGO_REG_W-1:0]    cp0_waddr,
    input  logic [`MANGO_DATA_W-1:0]   cp0_wdata,
    input  logic [`MANGO_REG_W-1:0]    cp0_raddr,
    output logic [`MANGO_DATA_W-1:0]   cp0_rdata,
    output logic [`MANGO_DATA_W-1:0]   cp0_status,
    output logic [`MANGO_DATA_W-1:0]   cp0_cause,
    output logic [`MANGO_ADDR_W-1:0]   cp0_epc
);

    import mango_pkg::*;

    logic [`MANGO_DATA_W-1:0] status_q;
    logic [`MANGO_DATA_W-1:0] cause_q;
    logic [`MANGO_ADDR_W-1:0] epc_q;
    logic [`MANGO_ADDR_W-1:0] badvaddr_q;
    logic                     exc_entry;
    logic                     exc_eret;
    logic                     baddr_upd;
    logic                     sw_write;

    assign exc_entry = (exc_type != NOEXC) && (exc_type != ERET);
    assign exc_eret  = (exc_type == ERET);
    // address error and tlb causes carry a bad address
    assign baddr_upd = exc_type inside {ADEL, ADES, TLBR, TLBI, TLBM};
    // any exception, eret included, blocks the software write
    assign sw_write  = cp0_we && (exc_type == NOEXC);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= '0;
            status_q[`MANGO_ST_BEV] <= 1'b1;
            cause_q <= '0;
            epc_q <= '0;
            badvaddr_q <= '0;
        end else begin
            cause_q[`MANGO_CA_IP_HW] <= hw_int;

            if (exc_entry) begin
                status_q[`MANGO_ST_EXL] <= 1'b1;
                cause_q[`MANGO_CA_EXCCODE] <= exc_code(exc_type);
                // nested entry keeps the first return address
                if (!status_q[`MANGO_ST_EXL]) begin
                    epc_q <= pc;
                end
                if (baddr_upd) begin
                    badvaddr_q <= exc_baddr;
                end
            end else if (exc_eret) begin
                status_q[`MANGO_ST_EXL] <= 1'b0;
                status_q[`MANGO_ST_ERL] <= 1'b0;
            end else if (sw_write) begin
                case (cp0_waddr)
                    `MANGO_CP0_STATUS: begin
                        status_q[`MANGO_ST_IM]  <= cp0_wdata[`MANGO_ST_IM];
                        status_q[`MANGO_ST_BEV] <= cp0_wdata[`MANGO_ST_BEV];
                        status_q[`MANGO_ST_ERL] <= cp0_wdata[`MANGO_ST_ERL];
                        status_q[`MANGO_ST_EXL] <= cp0_wdata[`MANGO_ST_EXL];
                        status_q[`MANGO_ST_IE]  <= cp0_wdata[`MANGO_ST_IE];
                    end
                    `MANGO_CP0_CAUSE: begin
                        // only the software interrupt bits are writable
                        cause_q[`MANGO_CA_IP_SW] <= cp0_wdata[`MANGO_CA_IP_SW];
                    end
                    `MANGO_CP0_EPC: begin
                        epc_q <= cp0_wdata;
                    end
                    default: begin
                        // badvaddr and unimplemented numbers ignore writes
                    end
                endcase
            end
        end
    end

    // mfc0 read mux
    always_comb begin
        case (cp0_raddr)
            `MANGO_CP0_BADVADDR: cp0_rdata = badvaddr_q;
            `MANGO_CP0_STATUS:   cp0_rdata = status_q;
            `MANGO_CP0_CAUSE:    cp0_rdata = cause_q;
            `MANGO_CP0_EPC:      cp0_rdata = epc_q;
            default:             cp0_rdata = '0;
        endcase
    end

    assign cp0_status = status_q;
    assign cp0_cause  = cause_q;
    assign cp0_epc    = epc_q;

endmodule

`default_nettype wire

/* hw/exc_prioritizer.sv */
// exc_prioritizer: interrupt detection, priority select of exception type, bad address select
`timescale 1ns/10ps
`default_nettype none
`include "mango_defines.svh"

module exc_prioritizer (
    input  logic                     inst_valid,
    input  logic [`MANGO_EXC_W-1:0]  excp,
    input  logic [`MANGO_DATA_W-1:0] cp0_status,
    input  logic [`MANGO_DATA_W-1:0] cp0_cause,
    input  logic [`MANGO_ADDR_W-1:0] pc,
    input  logic [`MANGO_ADDR_W-1:0] m_vaddr,
    output mango_pkg::exc_type_e     exc_type,
    output logic [`MANGO_ADDR_W-1:0] exc_baddr
);

    import mango_pkg::*;

    logic                    exc_intr;
    logic [`MANGO_EXC_W-1:0] excp_m;
    int                      win_idx;

    // pending interrupt, masked by IM and gated by IE/EXL/ERL
    assign exc_intr = (|(cp0_cause[`MANGO_CA_IP] & cp0_status[`MANGO_ST_IM]))
                      &&  cp0_status[`MANGO_ST_IE]
                      && !cp0_status[`MANGO_ST_ERL]
                      && !cp0_status[`MANGO_ST_EXL];

    // bit 1 is owned here, whatever arrives on it is replaced
    always_comb begin
        excp_m = excp;
        excp_m[`MANGO_EXC_INTR] = exc_intr;
    end

    // scan from eret down so the lowest set bit is the last hit
    always_comb begin
        win_idx = 0;
        if (inst_valid) begin
            for (int i = `MANGO_EXC_ERET; i >= `MANGO_EXC_INTR; i--) begin
                if (excp_m[i]) begin
                    win_idx = i;
                end
            end
        end
    end

    always_comb begin
        case (win_idx)
            `MANGO_EXC_INTR:   exc_type = INTR;
            `MANGO_EXC_I_ADEL: exc_type = ADEL;
            `MANGO_EXC_I_TLBR: exc_type = TLBR;
            `MANGO_EXC_I_TLBI: exc_type = TLBI;
            `MANGO_EXC_I_BUSE: exc_type = IBE;
            `MANGO_EXC_CPU:    exc_type = CPU;
            `MANGO_EXC_RI:     exc_type = RI;
            `MANGO_EXC_OV:     exc_type = OV;
            `MANGO_EXC_TRAP:   exc_type = TRAP;
            `MANGO_EXC_SYSC:   exc_type = SYSC;
            `MANGO_EXC_BP:     exc_type = BP;
            `MANGO_EXC_D_ADEL: exc_type = ADEL;
            `MANGO_EXC_D_ADES: exc_type = ADES;
            `MANGO_EXC_D_TLBR: exc_type = TLBR;
            `MANGO_EXC_D_TLBI: exc_type = TLBI;
            `MANGO_EXC_D_TLBM: exc_type = TLBM;
            `MANGO_EXC_D_BUSE: exc_type = DBE;
            `MANGO_EXC_ERET:   exc_type = ERET;
            default:           exc_type = NOEXC;
        endcase
    end

    // fetch side faults report pc, memory side faults the data address
    always_comb begin
        case (win_idx)
            `MANGO_EXC_I_ADEL, `MANGO_EXC_I_TLBR, `MANGO_EXC_I_TLBI:
                exc_baddr = pc;
            `MANGO_EXC_D_ADEL, `MANGO_EXC_D_ADES, `MANGO_EXC_D_TLBR,
            `MANGO_EXC_D_TLBI, `MANGO_EXC_D_TLBM:
                exc_baddr = m_vaddr;
            default:
                exc_baddr = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exc_redirect.sv */
// exc_redirect: pipeline flush and redirect pc from exception type, status and epc
`timescale 1ns/10ps
`default_nettype none
`include "mango_defines.svh"

module exc_redirect (
    input  mango_pkg::exc_type_e     exc_type,
    input  logic [`MANGO_DATA_W-1:0] cp0_status,
    input  logic [`MANGO_ADDR_W-1:0] cp0_epc,
    output logic                     flush,
    output logic [`MANGO_ADDR_W-1:0] redirect_pc
);

    import mango_pkg::*;

    logic [`MANGO_ADDR_W-1:0] vec_base;
    logic [`MANGO_ADDR_W-1:0] vec_ofs;

    assign flush = (exc_type != NOEXC);

    // bev selects the boot rom vectors
    assign vec_base = cp0_status[`MANGO_ST_BEV] ? `MANGO_VEC_BOOT_BASE
                                                 : `MANGO_VEC_NORMAL_BASE;

    // refill vector only for a tlb refill taken outside exception level
    assign vec_ofs = ((exc_type == TLBR) && !cp0_status[`MANGO_ST_EXL])
                   ? `MANGO_VEC_REFILL_OFS
                   : `MANGO_VEC_GEN_OFS;

    always_comb begin
        case (exc_type)
            ERET:    redirect_pc = cp0_epc;
            // no target without a flush
            NOEXC:   redirect_pc = '0;
            default: redirect_pc = vec_base + vec_ofs;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exc_unit_top.sv */
// exc_unit_top: exception stage built from prioritizer, cp0 registers and redirect logic
`timescale 1ns/10ps
`default_nettype none
`include "mango_defines.svh"

module exc_unit_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [`MANGO_EXC_W-1:0]   excp,
    input  logic [`MANGO_ADDR_W-1:0]  pc,
    input  logic [`MANGO_ADDR_W-1:0]  m_vaddr,
    input  logic [`MANGO_HWINT_W-1:0] hw_int,
    input  logic                      cp0_we,
    input  logic [`MANGO_REG_W-1:0]   cp0_waddr,
    input  logic [`MANGO_DATA_W-1:0]  cp0_wdata,
    input  logic [`MANGO_REG_W-1:0]   cp0_raddr,
    output logic [`MANGO_DATA_W-1:0]  cp0_rdata,
    output logic                      flush,
    output logic [`MANGO_ADDR_W-1:0]  redirect_pc,
    output mango_pkg::exc_type_e      exc_type
);

    logic [`MANGO_DATA_W-1:0] cp0_status;
    logic [`MANGO_DATA_W-1:0] cp0_cause;
    logic [`MANGO_ADDR_W-1:0] cp0_epc;
    logic [`MANGO_ADDR_W-1:0] exc_baddr;

    exc_prioritizer i_exc_prioritizer (
        .inst_valid (inst_valid),
        .excp       (excp),
        .cp0_status (cp0_status),
        .cp0_cause  (cp0_cause),
        .pc         (pc),
        .m_vaddr    (m_vaddr),
        .exc_type   (exc_type),
        .exc_baddr  (exc_baddr)
    );

    cp0_regs i_cp0_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .hw_int     (hw_int),
        .exc_type   (exc_type),
        .exc_baddr  (exc_baddr),
        .pc         (pc),
        .cp0_we     (cp0_we),
        .cp0_waddr  (cp0_waddr),
        .cp0_wdata  (cp0_wdata),
        .cp0_raddr  (cp0_raddr),
        .cp0_rdata  (cp0_rdata),
        .cp0_status (cp0_status),
        .cp0_cause  (cp0_cause),
        .cp0_epc    (cp0_epc)
    );

    exc_redirect i_exc_redirect (
        .exc_type    (exc_type),
        .cp0_status  (cp0_status),
        .cp0_epc     (cp0_epc),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

/* hw/mango_pkg.sv */
// exception type enum and its mapping to the mips excode field
`default_nettype none

package mango_pkg;

    typedef enum logic [4:0] {
        INTR  = 5'd0,
        ADEL  = 5'd1,
        ADES  = 5'd2,
        TLBR  = 5'd3,
        TLBI  = 5'd4,
        TLBM  = 5'd5,
        IBE   = 5'd6,
        DBE   = 5'd7,
        CPU   = 5'd8,
        RI    = 5'd9,
        OV    = 5'd10,
        TRAP  = 5'd11,
        SYSC  = 5'd12,
        BP    = 5'd13,
        ERET  = 5'd14,
        NOEXC = 5'd15
    } exc_type_e;

    // cause.exccode value for each type
    function automatic logic [4:0] exc_code(exc_type_e t);
        case (t)
            INTR:       return 5'd0;
            TLBM:       return 5'd1;
            TLBR, TLBI: return 5'd2;
            ADEL:       return 5'd4;
            ADES:       return 5'd5;
            IBE:        return 5'd6;
            DBE:        return 5'd7;
            SYSC:       return 5'd8;
            BP:         return 5'd9;
            RI:         return 5'd10;
            CPU:        return 5'd11;
            OV:         return 5'd12;
            TRAP:       return 5'd13;
            // eret and noexc never reach cause
            default:    return 5'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* include/mango_defines.svh */
// widths, request-vector bits, cp0 register numbers, field positions, vector addresses
`ifndef MANGO_DEFINES_SVH
`define MANGO_DEFINES_SVH

`define MANGO_DATA_W 32
`define MANGO_ADDR_W 32
`define MANGO_EXC_W 20
`define MANGO_HWINT_W 6
`define MANGO_REG_W 5

// request vector, lower index has higher priority
`define MANGO_EXC_INTR 1
`define MANGO_EXC_I_ADEL 2
`define MANGO_EXC_I_TLBR 3
`define MANGO_EXC_I_TLBI 4
`define MANGO_EXC_I_BUSE 5
`define MANGO_EXC_CPU 6
`define MANGO_EXC_RI 7
`define MANGO_EXC_OV 8
`define MANGO_EXC_TRAP 9
`define MANGO_EXC_SYSC 10
`define MANGO_EXC_BP 11
`define MANGO_EXC_D_ADEL 12
`define MANGO_EXC_D_ADES 13
`define MANGO_EXC_D_TLBR 14
`define MANGO_EXC_D_TLBI 15
`define MANGO_EXC_D_TLBM 16
`define MANGO_EXC_D_BUSE 17
`define MANGO_EXC_ERET 18

// cp0 register numbers
`define MANGO_CP0_BADVADDR 5'd8
`define MANGO_CP0_STATUS 5'd12
`define MANGO_CP0_CAUSE 5'd13
`define MANGO_CP0_EPC 5'd14

// status fields
`define MANGO_ST_IM 15:8
`define MANGO_ST_BEV 22
`define MANGO_ST_ERL 2
`define MANGO_ST_EXL 1
`define MANGO_ST_IE 0

// cause fields
`define MANGO_CA_IP 15:8
`define MANGO_CA_IP_HW 15:10
`define MANGO_CA_IP_SW 9:8
`define MANGO_CA_EXCCODE 6:2

// exception vectors
`define MANGO_VEC_BOOT_BASE 32'hBFC0_0200
`define MANGO_VEC_NORMAL_BASE 32'h8000_0000
`define MANGO_VEC_GEN_OFS 32'h0000_0180
`define MANGO_VEC_REFILL_OFS 32'h0000_0000

`endif

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module exc_unit_tb -f vlog.f -o exc_unit_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/exc_unit_sim > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && { echo "result: FAIL"; exit 1; } || echo "result: PASS"

/* test/exc_unit_asserts.sv */
// concurrent checks of flush against valid, exception type and reset
`timescale 1ns/10ps
`default_nettype none

module exc_unit_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 inst_valid,
    input logic                 flush,
    input mango_pkg::exc_type_e exc_type
);

    import mango_pkg::*;

    int fail_count = 0;

    // nothing to flush without an instruction
    flush_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) flush |-> inst_valid
    ) else begin
        fail_count++;
        $error("flush raised without a valid instruction");
    end

    flush_matches_type: assert property (
        @(posedge clk) disable iff (!rst_n) flush == (exc_type != NOEXC)
    ) else begin
        fail_count++;
        $error("flush disagrees with the exception type");
    end

    flush_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> !flush
    ) else begin
        fail_count++;
        $error("flush high while in reset");
    end

endmodule

`default_nettype wire

/* test/exc_unit_tb.sv */
// exception stage testbench with clock, reset, stimulus table, cp0 shadow model and random phase
`timescale 1ns/10ps
`default_nettype none
`include "mango_defines.svh"

module exc_unit_tb;

    import mango_pkg::*;

    localparam int          rand_cycles = 200;
    localparam int unsigned rand_seed   = 32'he138f542;
    // writable status fields im bev erl exl ie
    localparam logic [31:0] status_wmask = 32'h0040_FF07;

    typedef struct {
        logic                      valid;
        logic [`MANGO_EXC_W-1:0]   excp;
        logic [`MANGO_ADDR_W-1:0]  pc;
        logic [`MANGO_ADDR_W-1:0]  vaddr;
        logic [`MANGO_HWINT_W-1:0] hw;
        logic                      we;
        logic [`MANGO_REG_W-1:0]   waddr;
        logic [`MANGO_DATA_W-1:0]  wdata;
        exc_type_e                 t;
        logic                      flush;
        logic [`MANGO_ADDR_W-1:0]  redirect;
    } row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      inst_valid;
    logic [`MANGO_EXC_W-1:0]   excp;
    logic [`MANGO_ADDR_W-1:0]  pc;
    logic [`MANGO_ADDR_W-1:0]  m_vaddr;
    logic [`MANGO_HWINT_W-1:0] hw_int;
    logic                      cp0_we;
    logic [`MANGO_REG_W-1:0]   cp0_waddr;
    logic [`MANGO_DATA_W-1:0]  cp0_wdata;
    logic [`MANGO_REG_W-1:0]   cp0_raddr;
    logic [`MANGO_DATA_W-1:0]  cp0_rdata;
    logic                      flush;
    logic [`MANGO_ADDR_W-1:0]  redirect_pc;
    exc_type_e                 exc_type;

    // shadow copies of the cp0 registers
    logic [31:0] sh_status;
    logic [31:0] sh_cause;
    logic [31:0] sh_epc;
    logic [31:0] sh_badv;

    row_t rows[$];
    int   checks;
    int   errors;
    int   cycle_count;
    int   cycle_limit;

    exc_unit_top i_exc_unit_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .excp        (excp),
        .pc          (pc),
        .m_vaddr     (m_vaddr),
        .hw_int      (hw_int),
        .cp0_we      (cp0_we),
        .cp0_waddr   (cp0_waddr),
        .cp0_wdata   (cp0_wdata),
        .cp0_raddr   (cp0_raddr),
        .cp0_rdata   (cp0_rdata),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .exc_type    (exc_type)
    );

    bind exc_unit_top exc_unit_asserts i_exc_unit_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .flush      (flush),
        .exc_type   (exc_type)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    // readback order with entry 4 an unimplemented number
    function automatic logic [4:0] pick_addr(logic [2:0] s);
        case (s)
            3'd0, 3'd5: return `MANGO_CP0_BADVADDR;
            3'd1, 3'd6: return `MANGO_CP0_STATUS;
            3'd2, 3'd7: return `MANGO_CP0_CAUSE;
            3'd3:       return `MANGO_CP0_EPC;
            default:    return 5'd3;
        endcase
    endfunction

    function automatic logic [31:0] shadow_read(logic [4:0] a);
        case (a)
            `MANGO_CP0_BADVADDR: return sh_badv;
            `MANGO_CP0_STATUS:   return sh_status;
            `MANGO_CP0_CAUSE:    return sh_cause;
            `MANGO_CP0_EPC:      return sh_epc;
            default:             return 32'h0;
        endcase
    endfunction

    function automatic logic intr_pending();
        return (|(sh_cause[`MANGO_CA_IP] & sh_status[`MANGO_ST_IM]))
               && sh_status[`MANGO_ST_IE]
               && !sh_status[`MANGO_ST_EXL]
               && !sh_status[`MANGO_ST_ERL];
    endfunction

    // lowest set request bit from 1 to 18 or zero when none
    function automatic int winning_bit(logic valid, logic [`MANGO_EXC_W-1:0] req);
        logic [`MANGO_EXC_W-1:0] r;
        int win;
        r = req;
        r[`MANGO_EXC_INTR] = intr_pending();
        win = 0;
        if (valid) begin
            for (int i = 1; i <= `MANGO_EXC_ERET; i++) begin
                if (win == 0 && ((r >> i) & 20'd1) != 20'd0) begin
                    win = i;
                end
            end
        end
        return win;
    endfunction

    function automatic exc_type_e type_of_bit(int b);
        case (b)
            1:       return INTR;
            2, 12:   return ADEL;
            3, 14:   return TLBR;
            4, 15:   return TLBI;
            5:       return IBE;
            6:       return CPU;
            7:       return RI;
            8:       return OV;
            9:       return TRAP;
            10:      return SYSC;
            11:      return BP;
            13:      return ADES;
            16:      return TLBM;
            17:      return DBE;
            18:      return ERET;
            default: return NOEXC;
        endcase
    endfunction

    function automatic logic [4:0] code_of(exc_type_e t);
        case (t)
            TLBM:       return 5'd1;
            TLBR, TLBI: return 5'd2;
            ADEL:       return 5'd4;
            ADES:       return 5'd5;
            IBE:        return 5'd6;
            DBE:        return 5'd7;
            SYSC:       return 5'd8;
            BP:         return 5'd9;
            RI:         return 5'd10;
            CPU:        return 5'd11;
            OV:         return 5'd12;
            TRAP:       return 5'd13;
            default:    return 5'd0;
        endcase
    endfunction

    function automatic logic [31:0] redirect_of(exc_type_e t);
        logic [31:0] base;
        logic [31:0] ofs;
        base = sh_status[`MANGO_ST_BEV] ? 32'hBFC0_0200 : 32'h8000_0000;
        ofs = (t == TLBR && !sh_status[`MANGO_ST_EXL]) ? 32'h0 : 32'h180;
        if (t == ERET) begin
            return sh_epc;
        end
        return base + ofs;
    endfunction

    // advance the shadow registers by one clock edge
    task automatic commit_model();
        int win;
        exc_type_e t;
        logic old_exl;
        win = winning_bit(inst_valid, excp);
        t = type_of_bit(win);
        old_exl = sh_status[`MANGO_ST_EXL];
        sh_cause[`MANGO_CA_IP_HW] = hw_int;
        if (t != NOEXC && t != ERET) begin
            sh_status[`MANGO_ST_EXL] = 1'b1;
            sh_cause[`MANGO_CA_EXCCODE] = code_of(t);
            if (!old_exl) begin
                sh_epc = pc;
            end
            if (win >= 2 && win <= 4) begin
                sh_badv = pc;
            end else if (win >= 12 && win <= 16) begin
                sh_badv = m_vaddr;
            end
        end else if (t == ERET) begin
            sh_status[`MANGO_ST_EXL] = 1'b0;
            sh_status[`MANGO_ST_ERL] = 1'b0;
        end else if (cp0_we) begin
            case (cp0_waddr)
                `MANGO_CP0_STATUS: sh_status = (sh_status & ~status_wmask)
                                               | (cp0_wdata & status_wmask);
                `MANGO_CP0_CAUSE:  sh_cause[`MANGO_CA_IP_SW] = cp0_wdata[`MANGO_CA_IP_SW];
                `MANGO_CP0_EPC:    sh_epc = cp0_wdata;
                default:           sh_epc = sh_epc;
            endcase
        end
    endtask

    task automatic readback_all();
        logic [4:0] a;
        for (int k = 0; k < 5; k++) begin
            a = pick_addr(3'(k));
            cp0_raddr = a;
            #2;
            check_value($sformatf("cp0_rdata[%0d]", a), shadow_read(a), cp0_rdata);
        end
    endtask

    // inputs are already driven at the falling edge
    task automatic apply_and_check(input exc_type_e t_exp, input logic f_exp,
                                   input logic [31:0] r_exp);
        #5;
        check_value("exc_type", 32'(t_exp), 32'(exc_type));
        check_value("flush", 32'(f_exp), 32'(flush));
        if (f_exp) begin
            check_value("redirect_pc", r_exp, redirect_pc);
        end
        @(posedge clk);
        commit_model();
        #5;
        readback_all();
        @(negedge clk);
    endtask

    function automatic void add_row(int v, int x, int p, int a, int h, int we, int wa,
                                    int wd, exc_type_e t, int f, int r);
        row_t n;
        n.valid = v[0];
        n.excp = x[19:0];
        n.pc = p;
        n.vaddr = a;
        n.hw = h[5:0];
        n.we = we[0];
        n.waddr = wa[4:0];
        n.wdata = wd;
        n.t = t;
        n.flush = f[0];
        n.redirect = r;
        rows.push_back(n);
    endfunction

    task automatic drive_row(input row_t n);
        inst_valid = n.valid;
        excp = n.excp;
        pc = n.pc;
        m_vaddr = n.vaddr;
        hw_int = n.hw;
        cp0_we = n.we;
        cp0_waddr = n.waddr;
        cp0_wdata = n.wdata;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] c;
        logic [19:0] req;
        // four ands keep about one request bit set per cycle
        req = '1;
        repeat (4) begin
            r = $urandom;
            req = req & r[19:0];
        end
        c = $urandom;
        inst_valid = (c[1:0] != 2'b00);
        excp = req;
        hw_int = c[7:2] & c[13:8];
        cp0_we = (c[15:14] == 2'b11);
        cp0_waddr = pick_addr(c[18:16]);
        cp0_wdata = $urandom;
        pc = $urandom;
        m_vaddr = $urandom;
    endtask

    task automatic build_table();
        add_row(0, 32'h00000, 32'h00400000, 0, 0, 0, 0, 0, NOEXC, 0, 0);
        add_row(1, 32'h80000, 32'h00400004, 0, 0, 0, 0, 0, NOEXC, 0, 0);
        add_row(0, 32'h00080, 32'h00400008, 0, 0, 0, 0, 0, NOEXC, 0, 0);
        // lowest of several requests wins
        add_row(1, 32'h40480, 32'h00400010, 0, 0, 0, 0, 0, RI, 1, 32'hBFC00380);
        // nested entry keeps the first pc in epc
        add_row(1, 32'h01000, 32'h00400020, 32'h10000003, 0, 0, 0, 0, ADEL, 1, 32'hBFC00380);
        add_row(1, 32'h40000, 32'h00400030, 0, 0, 0, 0, 0, ERET, 1, 32'h00400010);
        add_row(0, 32'h00000, 32'h00400040, 0, 0, 1, 12, 32'h0000FF01, NOEXC, 0, 0);
        add_row(0, 32'h00000, 32'h00400050, 0, 4, 1, 14, 32'h80001234, NOEXC, 0, 0);
        // pending hw line 2 outranks the fetch fault
        add_row(1, 32'h00404, 32'h00400100, 0, 0, 0, 0, 0, INTR, 1, 32'h80000180);
        add_row(1, 32'h00800, 32'h00400200, 0, 1, 0, 0, 0, BP, 1, 32'h80000180);
        // interrupt held off by exl
        add_row(1, 32'h00100, 32'h00400210, 0, 1, 0, 0, 0, OV, 1, 32'h80000180);
        add_row(1, 32'h40000, 32'h00400220, 0, 0, 0, 0, 0, ERET, 1, 32'h00400100);
        add_row(0, 32'h00000, 32'h00400230, 0, 0, 1, 12, 32'h00000101, NOEXC, 0, 0);
        add_row(0, 32'h00000, 32'h00400240, 0, 0, 1, 13, 32'h00000200, NOEXC, 0, 0);
        // sw ip 9 masked by im
        add_row(1, 32'h00200, 32'h00400300, 0, 0, 0, 0, 0, TRAP, 1, 32'h80000180);
        add_row(1, 32'h40000, 32'h00400310, 0, 0, 0, 0, 0, ERET, 1, 32'h00400300);
        // exception overrides the epc write
        add_row(1, 32'h02000, 32'h00400400, 32'h20000001, 0, 1, 14, 32'hDEADBEE0,
                ADES, 1, 32'h80000180);
        add_row(1, 32'h00008, 32'h00400500, 0, 0, 0, 0, 0, TLBR, 1, 32'h80000180);
        add_row(1, 32'h40000, 32'h00400510, 0, 0, 0, 0, 0, ERET, 1, 32'h00400400);
        add_row(1, 32'h04000, 32'h00400600, 32'h30000000, 0, 0, 0, 0, TLBR, 1, 32'h80000000);
        add_row(0, 32'h00000, 32'h00400610, 0, 0, 1, 12, 32'h00400000, NOEXC, 0, 0);
        add_row(1, 32'h00008, 32'h00400700, 0, 0, 0, 0, 0, TLBR, 1, 32'hBFC00200);
        add_row(0, 32'h00000, 32'h00400710, 0, 0, 1, 12, 32'h00000201, NOEXC, 0, 0);
        add_row(1, 32'h20020, 32'h00400800, 0, 0, 0, 0, 0, INTR, 1, 32'h80000180);
        add_row(1, 32'h00020, 32'h00400900, 0, 0, 0, 0, 0, IBE, 1, 32'h80000180);
        add_row(1, 32'h20000, 32'h00400910, 0, 0, 0, 0, 0, DBE, 1, 32'h80000180);
        add_row(1, 32'h08000, 32'h00400920, 32'h40000008, 0, 0, 0, 0, TLBI, 1, 32'h80000180);
        add_row(1, 32'h10000, 32'h00400930, 32'h5000000C, 0, 0, 0, 0, TLBM, 1, 32'h80000180);
        add_row(1, 32'h00040, 32'h00400940, 0, 0, 0, 0, 0, CPU, 1, 32'h80000180);
        add_row(1, 32'h00400, 32'h00400950, 0, 0, 0, 0, 0, SYSC, 1, 32'h80000180);
        add_row(1, 32'h40000, 32'h00400960, 0, 0, 0, 0, 0, ERET, 1, 32'h00400800);
        add_row(0, 32'h00000, 32'h00400970, 0, 0, 1, 13, 32'h00000000, NOEXC, 0, 0);
        add_row(1, 32'h00010, 32'h00400980, 0, 0, 0, 0, 0, TLBI, 1, 32'h80000180);
        add_row(1, 32'h00004, 32'h00400990, 0, 0, 0, 0, 0, ADEL, 1, 32'h80000180);
    endtask

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int err_mark;
        exc_type_e t_exp;
        void'($urandom(rand_seed));
        rst_n = 1'b0;
        inst_valid = 1'b0;
        excp = '0;
        pc = '0;
        m_vaddr = '0;
        hw_int = '0;
        cp0_we = 1'b0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = '0;
        checks = 0;
        errors = 0;
        cycle_count = 0;
        build_table();
        cycle_limit = 4 + rows.size() + rand_cycles + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        sh_status = '0;
        sh_status[`MANGO_ST_BEV] = 1'b1;
        sh_cause = '0;
        sh_epc = '0;
        sh_badv = '0;
        err_mark = errors;
        readback_all();
        $display("reset readback: %s", (errors == err_mark) ? "ok" : "mismatch");
        foreach (rows[i]) begin
            err_mark = errors;
            drive_row(rows[i]);
            apply_and_check(rows[i].t, rows[i].flush, rows[i].redirect);
            $display("row %0d: %s", i, (errors == err_mark) ? "ok" : "mismatch");
        end
        err_mark = errors;
        for (int n = 0; n < rand_cycles; n++) begin
            drive_random();
            t_exp = type_of_bit(winning_bit(inst_valid, excp));
            apply_and_check(t_exp, t_exp != NOEXC, redirect_of(t_exp));
        end
        $display("random phase: %0d cycles, %0d errors", rand_cycles, errors - err_mark);
        errors += i_exc_unit_top.i_exc_unit_asserts.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/mango_pkg.sv
hw/exc_prioritizer.sv
hw/cp0_regs.sv
hw/exc_redirect.sv
hw/exc_unit_top.sv
test/exc_unit_asserts.sv
test/exc_unit_tb.sv
